// File: hdl/id_queue_pkg.sv
/* Shared sizes of the ID queue: ID, data and table widths and capacities */

package id_queue_pkg;

    // Every element carries an ID of this many bits
    localparam int ID_WIDTH = 2;

    // Number of distinct IDs that the ID field can express
    localparam int NUM_IDS = 4;

    // Width of one element's data, also used for the exists query and its mask
    localparam int DATA_WIDTH = 16;

    // Total number of elements held across all IDs
    localparam int CAPACITY = 8;

    // The head-tail table never needs more rows than there are IDs or elements
    localparam int HT_CAPACITY = 4;

    // Index into the head-tail table
    localparam int HT_IDX_WIDTH = 2;

    // Index into the linked data table, also the width of a next pointer
    localparam int LD_IDX_WIDTH = 3;

endpackage

// File: hdl/id_queue_lookup.sv
/* Decode step of the ID queue: ID match against the head-tail table,
   first-free search over both tables, grants and push/pop enables */

`timescale 1ns/100ps

module id_queue_lookup (
    input  logic [id_queue_pkg::ID_WIDTH-1:0]       inp_id_i,
    input  logic                                    inp_req_i,
    input  logic [id_queue_pkg::ID_WIDTH-1:0]       oup_id_i,
    input  logic                                    oup_pop_i,
    input  logic                                    oup_req_i,
    input  logic                                    exists_req_i,
    input  logic [id_queue_pkg::HT_CAPACITY-1:0][id_queue_pkg::ID_WIDTH-1:0] row_id_i,
    input  logic [id_queue_pkg::HT_CAPACITY-1:0]    row_free_i,
    input  logic [id_queue_pkg::CAPACITY-1:0]       slot_free_i,
    output logic                                    inp_gnt_o,
    output logic                                    oup_gnt_o,
    output logic                                    exists_gnt_o,
    output logic                                    push_o,
    output logic                                    pop_o,
    output logic                                    row_hit_o,
    output logic [id_queue_pkg::HT_IDX_WIDTH-1:0]   row_idx_o,
    output logic [id_queue_pkg::HT_IDX_WIDTH-1:0]   free_row_o,
    output logic [id_queue_pkg::LD_IDX_WIDTH-1:0]   free_slot_o
);

    logic [id_queue_pkg::ID_WIDTH-1:0]      lookup_id;
    logic [id_queue_pkg::NUM_IDS-1:0]       lookup_onehot;
    logic [id_queue_pkg::HT_CAPACITY-1:0]   row_match;
    logic                                   full;

    // The queue is full once no linked data slot is left
    assign full = ~|slot_free_i;

    // Push has priority, so the output port only gets the table when no push happens
    assign inp_gnt_o    = ~full;
    assign push_o       = inp_req_i & inp_gnt_o;
    assign oup_gnt_o    = oup_req_i & ~push_o;
    assign exists_gnt_o = exists_req_i;

    // Only one port uses the ID match in a cycle, so one comparator bank serves both
    assign lookup_id = push_o ? inp_id_i : oup_id_i;

    always_comb begin
        lookup_onehot            = '0;
        lookup_onehot[lookup_id] = 1'b1;
    end

    // A row matches when it is occupied and holds the lookup ID
    always_comb begin
        for (int i = 0; i < id_queue_pkg::HT_CAPACITY; i++) begin
            row_match[i] = ~row_free_i[i] & lookup_onehot[row_id_i[i]];
        end
    end

    // At most one row holds a given ID, so OR-ing the indices encodes the one-hot match
    always_comb begin
        row_idx_o = '0;
        for (int i = 0; i < id_queue_pkg::HT_CAPACITY; i++) begin
            if (row_match[i]) begin
                row_idx_o = row_idx_o | i[id_queue_pkg::HT_IDX_WIDTH-1:0];
            end
        end
    end

    assign row_hit_o = |row_match;

    // Pop only when the output is granted and the requested ID is stored
    assign pop_o = oup_gnt_o & oup_pop_i & row_hit_o;

    // Lowest free head-tail row; scanning downward lets the lowest index win
    always_comb begin
        free_row_o = '0;
        for (int i = id_queue_pkg::HT_CAPACITY - 1; i >= 0; i--) begin
            if (row_free_i[i]) begin
                free_row_o = i[id_queue_pkg::HT_IDX_WIDTH-1:0];
            end
        end
    end

    // Lowest free linked data slot, same scheme
    always_comb begin
        free_slot_o = '0;
        for (int i = id_queue_pkg::CAPACITY - 1; i >= 0; i--) begin
            if (slot_free_i[i]) begin
                free_slot_o = i[id_queue_pkg::LD_IDX_WIDTH-1:0];
            end
        end
    end

endmodule

// File: hdl/id_queue_tables.sv
/* Execute step of the ID queue with the head-tail table and the linked data table,
   updated by one push or one pop per clock */

`timescale 1ns/100ps

module id_queue_tables (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic                                    push_i,
    input  logic                                    pop_i,
    input  logic                                    row_hit_i,
    input  logic [id_queue_pkg::HT_IDX_WIDTH-1:0]   row_idx_i,
    input  logic [id_queue_pkg::HT_IDX_WIDTH-1:0]   free_row_i,
    input  logic [id_queue_pkg::LD_IDX_WIDTH-1:0]   free_slot_i,
    input  logic [id_queue_pkg::ID_WIDTH-1:0]       inp_id_i,
    input  logic [id_queue_pkg::DATA_WIDTH-1:0]     inp_data_i,
    output logic [id_queue_pkg::HT_CAPACITY-1:0][id_queue_pkg::ID_WIDTH-1:0] row_id_o,
    output logic [id_queue_pkg::HT_CAPACITY-1:0]    row_free_o,
    output logic [id_queue_pkg::CAPACITY-1:0]       slot_free_o,
    output logic [id_queue_pkg::CAPACITY-1:0][id_queue_pkg::DATA_WIDTH-1:0] slot_data_o,
    output logic [id_queue_pkg::DATA_WIDTH-1:0]     head_data_o
);

    // Head-tail table, one row per stored ID
    logic [id_queue_pkg::HT_CAPACITY-1:0][id_queue_pkg::ID_WIDTH-1:0]     row_id_q;
    logic [id_queue_pkg::HT_CAPACITY-1:0][id_queue_pkg::LD_IDX_WIDTH-1:0] row_head_q;
    logic [id_queue_pkg::HT_CAPACITY-1:0][id_queue_pkg::LD_IDX_WIDTH-1:0] row_tail_q;
    logic [id_queue_pkg::HT_CAPACITY-1:0]                                 row_free_q;

    // Linked data table, one slot per stored element
    logic [id_queue_pkg::CAPACITY-1:0][id_queue_pkg::DATA_WIDTH-1:0]      slot_data_q;
    logic [id_queue_pkg::CAPACITY-1:0][id_queue_pkg::LD_IDX_WIDTH-1:0]    slot_next_q;
    logic [id_queue_pkg::CAPACITY-1:0]                                    slot_free_q;

    // Head and tail of the matched row serve both push and pop
    logic [id_queue_pkg::LD_IDX_WIDTH-1:0] hit_head;
    logic [id_queue_pkg::LD_IDX_WIDTH-1:0] hit_tail;

    assign hit_head = row_head_q[row_idx_i];
    assign hit_tail = row_tail_q[row_idx_i];

    // Pointers and free flags
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            row_id_q    <= '0;
            row_head_q  <= '0;
            row_tail_q  <= '0;
            row_free_q  <= '1;
            slot_next_q <= '0;
            slot_free_q <= '1;
        end else if (push_i) begin
            // The new element always goes to the lowest free slot
            slot_free_q[free_slot_i] <= 1'b0;
            if (row_hit_i) begin
                // An ID already stored links behind the current tail
                slot_next_q[hit_tail] <= free_slot_i;
                row_tail_q[row_idx_i] <= free_slot_i;
            end else begin
                // First element of this ID claims a fresh row
                row_id_q[free_row_i]   <= inp_id_i;
                row_head_q[free_row_i] <= free_slot_i;
                row_tail_q[free_row_i] <= free_slot_i;
                row_free_q[free_row_i] <= 1'b0;
            end
        end else if (pop_i) begin
            slot_free_q[hit_head] <= 1'b1;
            if (hit_head == hit_tail) begin
                // The row is released when the last element of its ID leaves
                row_free_q[row_idx_i] <= 1'b1;
            end else begin
                row_head_q[row_idx_i] <= slot_next_q[hit_head];
            end
        end
    end

    // Element data goes into the slot that the push claims
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            slot_data_q[free_slot_i] <= inp_data_i;
        end
    end

    assign row_id_o    = row_id_q;
    assign row_free_o  = row_free_q;
    assign slot_free_o = slot_free_q;
    assign slot_data_o = slot_data_q;

    // Oldest element of the matched ID; meaningless when the row did not hit
    assign head_data_o = slot_data_q[hit_head];

endmodule

// File: hdl/id_queue_result.sv
/* Result step of the ID queue: gated output data and the masked exists search */

`timescale 1ns/100ps

module id_queue_result (
    input  logic                                    oup_gnt_i,
    input  logic                                    row_hit_i,
    input  logic [id_queue_pkg::DATA_WIDTH-1:0]     head_data_i,
    input  logic [id_queue_pkg::CAPACITY-1:0][id_queue_pkg::DATA_WIDTH-1:0] slot_data_i,
    input  logic [id_queue_pkg::CAPACITY-1:0]       slot_free_i,
    input  logic [id_queue_pkg::DATA_WIDTH-1:0]     exists_data_i,
    input  logic [id_queue_pkg::DATA_WIDTH-1:0]     exists_mask_i,
    input  logic                                    exists_gnt_i,
    output logic [id_queue_pkg::DATA_WIDTH-1:0]     oup_data_o,
    output logic                                    oup_data_valid_o,
    output logic                                    exists_o
);

    logic [id_queue_pkg::CAPACITY-1:0] slot_match;

    // Data is only shown for a granted read of a stored ID, zero otherwise
    assign oup_data_valid_o = oup_gnt_i & row_hit_i;
    assign oup_data_o       = oup_data_valid_o ? head_data_i : '0;

    // An occupied slot matches when it differs from the query on no masked bit
    always_comb begin
        for (int i = 0; i < id_queue_pkg::CAPACITY; i++) begin
            slot_match[i] = ~slot_free_i[i] &
                            ~|((slot_data_i[i] ^ exists_data_i) & exists_mask_i);
        end
    end

    // Any match anywhere in the queue answers the query
    assign exists_o = exists_gnt_i & |slot_match;

endmodule

// File: hdl/id_queue.sv
/* ID queue top level: per-ID FIFO order with push, output and masked exists ports */

`timescale 1ns/100ps

module id_queue (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic [id_queue_pkg::ID_WIDTH-1:0]   inp_id_i,
    input  logic [id_queue_pkg::DATA_WIDTH-1:0] inp_data_i,
    input  logic                                inp_req_i,
    output logic                                inp_gnt_o,

    input  logic [id_queue_pkg::ID_WIDTH-1:0]   oup_id_i,
    input  logic                                oup_pop_i,
    input  logic                                oup_req_i,
    output logic [id_queue_pkg::DATA_WIDTH-1:0] oup_data_o,
    output logic                                oup_data_valid_o,
    output logic                                oup_gnt_o,

    input  logic [id_queue_pkg::DATA_WIDTH-1:0] exists_data_i,
    input  logic [id_queue_pkg::DATA_WIDTH-1:0] exists_mask_i,
    input  logic                                exists_req_i,
    output logic                                exists_o,
    output logic                                exists_gnt_o
);

    // Decode to execute: enables and the table positions they act on
    logic                                       push;
    logic                                       pop;
    logic                                       row_hit;
    logic [id_queue_pkg::HT_IDX_WIDTH-1:0]      row_idx;
    logic [id_queue_pkg::HT_IDX_WIDTH-1:0]      free_row;
    logic [id_queue_pkg::LD_IDX_WIDTH-1:0]      free_slot;

    // Execute back to decode: table state seen at the start of the cycle
    logic [id_queue_pkg::HT_CAPACITY-1:0][id_queue_pkg::ID_WIDTH-1:0] row_id;
    logic [id_queue_pkg::HT_CAPACITY-1:0]       row_free;
    logic [id_queue_pkg::CAPACITY-1:0]          slot_free;

    // Execute to result: stored data for the output and exists paths
    logic [id_queue_pkg::CAPACITY-1:0][id_queue_pkg::DATA_WIDTH-1:0] slot_data;
    logic [id_queue_pkg::DATA_WIDTH-1:0]        head_data;

    id_queue_lookup u_lookup (
        .inp_id_i     (inp_id_i),
        .inp_req_i    (inp_req_i),
        .oup_id_i     (oup_id_i),
        .oup_pop_i    (oup_pop_i),
        .oup_req_i    (oup_req_i),
        .exists_req_i (exists_req_i),
        .row_id_i     (row_id),
        .row_free_i   (row_free),
        .slot_free_i  (slot_free),
        .inp_gnt_o    (inp_gnt_o),
        .oup_gnt_o    (oup_gnt_o),
        .exists_gnt_o (exists_gnt_o),
        .push_o       (push),
        .pop_o        (pop),
        .row_hit_o    (row_hit),
        .row_idx_o    (row_idx),
        .free_row_o   (free_row),
        .free_slot_o  (free_slot)
    );

    id_queue_tables u_tables (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .pop_i       (pop),
        .row_hit_i   (row_hit),
        .row_idx_i   (row_idx),
        .free_row_i  (free_row),
        .free_slot_i (free_slot),
        .inp_id_i    (inp_id_i),
        .inp_data_i  (inp_data_i),
        .row_id_o    (row_id),
        .row_free_o  (row_free),
        .slot_free_o (slot_free),
        .slot_data_o (slot_data),
        .head_data_o (head_data)
    );

    id_queue_result u_result (
        .oup_gnt_i        (oup_gnt_o),
        .row_hit_i        (row_hit),
        .head_data_i      (head_data),
        .slot_data_i      (slot_data),
        .slot_free_i      (slot_free),
        .exists_data_i    (exists_data_i),
        .exists_mask_i    (exists_mask_i),
        .exists_gnt_i     (exists_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .exists_o         (exists_o)
    );

endmodule

// File: dv/id_queue_chk.sv
/* Bound checker for the ID queue grant and valid rules */

`timescale 1ns/100ps

module id_queue_chk (
    input logic clk_i,
    input logic rst_ni,
    input logic inp_req_i,
    input logic inp_gnt_i,
    input logic oup_gnt_i,
    input logic oup_data_valid_i,
    input logic exists_req_i,
    input logic exists_gnt_i
);

    // Count of assertion failures so far
    int unsigned error_count = 0;

    // The output port has to wait while a push owns the tables
    push_blocks_output: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(inp_req_i && inp_gnt_i && oup_gnt_i)
    ) else begin
        error_count++;
        $error("Output port granted in a cycle with a push");
    end

    // Data is only ever shown on a granted read
    valid_needs_grant: assert property (
        @(posedge clk_i) disable iff (!rst_ni) oup_data_valid_i |-> oup_gnt_i
    ) else begin
        error_count++;
        $error("Output data valid without an output grant");
    end

    // The exists port never competes with anything
    exists_grant_follows_req: assert property (
        @(posedge clk_i) disable iff (!rst_ni) exists_gnt_i == exists_req_i
    ) else begin
        error_count++;
        $error("Exists grant differs from its request");
    end

endmodule

// File: dv/tb_id_queue.sv
/* Directed testbench for the ID queue with clock, reset, a per-ID reference model,
   one task per behavior and a watchdog */

`timescale 1ns/100ps

module tb_id_queue;

    localparam int CLK_PERIOD    = 40;
    localparam int SAMPLE_DELAY  = CLK_PERIOD / 4;
    localparam int RESET_CYCLES  = 16;
    // Cycle budgets of the six tests in run order
    localparam int TEST_CYCLES   = 8 + 24 + 12 + 24 + 6 + 24;
    localparam int MARGIN_CYCLES = 50;

    logic clk_i, rst_ni;
    logic [id_queue_pkg::ID_WIDTH-1:0]   inp_id_i, oup_id_i;
    logic [id_queue_pkg::DATA_WIDTH-1:0] inp_data_i, oup_data_o, exists_data_i, exists_mask_i;
    logic inp_req_i, inp_gnt_o, oup_pop_i, oup_req_i, oup_data_valid_o, oup_gnt_o;
    logic exists_req_i, exists_o, exists_gnt_o;

    // Reference model keeps one FIFO per ID with the oldest element at index 0
    integer seed;
    logic [id_queue_pkg::DATA_WIDTH-1:0] model_data [id_queue_pkg::NUM_IDS][id_queue_pkg::CAPACITY];
    int model_count [id_queue_pkg::NUM_IDS];

    id_queue uut (.*);

    bind id_queue id_queue_chk u_chk (
        .clk_i(clk_i), .rst_ni(rst_ni), .inp_req_i(inp_req_i), .inp_gnt_i(inp_gnt_o),
        .oup_gnt_i(oup_gnt_o), .oup_data_valid_i(oup_data_valid_o),
        .exists_req_i(exists_req_i), .exists_gnt_i(exists_gnt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Ends a run that stalls on a grant that never comes
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    // A failed assertion in the bound checker ends the run at once
    initial begin
        wait (uut.u_chk.error_count != 0);
        $display("The bound checker flagged an assertion failure");
        $display("tests failed");
        $fatal(1, "assertion failure");
    end

    task automatic compare_values(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [id_queue_pkg::DATA_WIDTH-1:0] random_data();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[id_queue_pkg::DATA_WIDTH-1:0];
    endfunction

    function automatic int model_total();
        int sum;
        sum = 0;
        for (int i = 0; i < id_queue_pkg::NUM_IDS; i++) begin
            sum += model_count[i];
        end
        return sum;
    endfunction

    // Any stored element equal to the query on every masked bit
    function automatic logic model_exists(input logic [id_queue_pkg::DATA_WIDTH-1:0] data,
                                          input logic [id_queue_pkg::DATA_WIDTH-1:0] mask);
        logic found;
        found = 1'b0;
        for (int i = 0; i < id_queue_pkg::NUM_IDS; i++) begin
            for (int k = 0; k < model_count[i]; k++) begin
                if (((model_data[i][k] ^ data) & mask) == '0) begin
                    found = 1'b1;
                end
            end
        end
        return found;
    endfunction

    task automatic drive_idle();
        inp_req_i    = 1'b0;
        oup_req_i    = 1'b0;
        oup_pop_i    = 1'b0;
        exists_req_i = 1'b0;
    endtask

    task automatic push_elem(input int id, input logic [id_queue_pkg::DATA_WIDTH-1:0] data);
        @(negedge clk_i);
        drive_idle();
        inp_req_i  = 1'b1;
        inp_id_i   = id[id_queue_pkg::ID_WIDTH-1:0];
        inp_data_i = data;
        // Request stays up until the queue grants it
        #(SAMPLE_DELAY);
        while (!inp_gnt_o) begin
            @(negedge clk_i);
            #(SAMPLE_DELAY);
        end
        model_data[id][model_count[id]] = data;
        model_count[id]++;
        @(posedge clk_i);
    endtask

    task automatic read_elem(input int id, input logic pop);
        logic                                exp_valid;
        logic [id_queue_pkg::DATA_WIDTH-1:0] exp_data;
        @(negedge clk_i);
        drive_idle();
        oup_req_i = 1'b1;
        oup_id_i  = id[id_queue_pkg::ID_WIDTH-1:0];
        oup_pop_i = pop;
        #(SAMPLE_DELAY);
        exp_valid = model_count[id] > 0;
        exp_data  = exp_valid ? model_data[id][0] : '0;
        compare_values("inp_gnt_o", 32'(inp_gnt_o),
                       32'(model_total() < id_queue_pkg::CAPACITY));
        compare_values("oup_gnt_o", 32'(oup_gnt_o), 32'd1);
        compare_values("oup_data_valid_o", 32'(oup_data_valid_o), 32'(exp_valid));
        compare_values("oup_data_o", 32'(oup_data_o), 32'(exp_data));
        // Popping a stored ID drops its oldest element at the next edge
        if (pop && exp_valid) begin
            for (int k = 0; k < model_count[id] - 1; k++) begin
                model_data[id][k] = model_data[id][k + 1];
            end
            model_count[id]--;
        end
        @(posedge clk_i);
    endtask

    task automatic exists_query(input logic [id_queue_pkg::DATA_WIDTH-1:0] data,
                                input logic [id_queue_pkg::DATA_WIDTH-1:0] mask);
        @(negedge clk_i);
        drive_idle();
        exists_req_i  = 1'b1;
        exists_data_i = data;
        exists_mask_i = mask;
        #(SAMPLE_DELAY);
        compare_values("exists_gnt_o", 32'(exists_gnt_o), 32'd1);
        compare_values("exists_o", 32'(exists_o), 32'(model_exists(data, mask)));
        @(posedge clk_i);
    endtask

    task automatic drain_all();
        for (int id = 0; id < id_queue_pkg::NUM_IDS; id++) begin
            while (model_count[id] > 0) begin
                read_elem(id, 1'b1);
            end
        end
    endtask

    task automatic test_empty_state();
        for (int id = 0; id < id_queue_pkg::NUM_IDS; id++) begin
            read_elem(id, 1'b0);
        end
        exists_query(random_data(), '1);
    endtask

    // IDs interleave and then each ID drains and reads once more while empty
    task automatic test_fifo_order();
        for (int i = 0; i < 7; i++) begin
            push_elem((i * 3) % id_queue_pkg::NUM_IDS, random_data());
        end
        for (int id = 0; id < id_queue_pkg::NUM_IDS; id++) begin
            while (model_count[id] > 0) begin
                read_elem(id, 1'b1);
            end
            read_elem(id, 1'b1);
        end
    endtask

    task automatic test_read_vs_pop();
        repeat (3) push_elem(1, random_data());
        read_elem(1, 1'b0);
        read_elem(1, 1'b0);
        read_elem(1, 1'b1);
        read_elem(1, 1'b0);
        drain_all();
    endtask

    task automatic test_full_refill();
        for (int i = 0; i < id_queue_pkg::CAPACITY; i++) begin
            push_elem(i % id_queue_pkg::NUM_IDS, random_data());
        end
        // One more push attempt while full must not be granted
        @(negedge clk_i);
        drive_idle();
        inp_req_i  = 1'b1;
        inp_id_i   = '0;
        inp_data_i = random_data();
        #(SAMPLE_DELAY);
        compare_values("inp_gnt_o", 32'(inp_gnt_o), 32'd0);
        @(posedge clk_i);
        read_elem(2, 1'b1);
        push_elem(3, random_data());
        drain_all();
    endtask

    // A push and a popping read of a stored ID collide and only the push may land
    task automatic test_push_priority();
        logic [id_queue_pkg::DATA_WIDTH-1:0] data;
        push_elem(1, random_data());
        data = random_data();
        @(negedge clk_i);
        drive_idle();
        inp_req_i  = 1'b1;
        inp_id_i   = 2'd1;
        inp_data_i = data;
        oup_req_i  = 1'b1;
        oup_id_i   = 2'd1;
        oup_pop_i  = 1'b1;
        #(SAMPLE_DELAY);
        compare_values("inp_gnt_o", 32'(inp_gnt_o), 32'd1);
        compare_values("oup_gnt_o", 32'(oup_gnt_o), 32'd0);
        compare_values("oup_data_valid_o", 32'(oup_data_valid_o), 32'd0);
        model_data[1][model_count[1]] = data;
        model_count[1]++;
        @(posedge clk_i);
        // The older element is still there and the pushed one follows it
        read_elem(1, 1'b1);
        drain_all();
    endtask

    task automatic test_masked_exists();
        push_elem(0, 16'h1234);
        push_elem(1, 16'habcd);
        push_elem(2, 16'h12f0);
        exists_query(16'h1200, 16'hff00);
        exists_query(16'h0034, 16'h00ff);
        exists_query(16'h5555, 16'hffff);
        exists_query(16'h0000, 16'h0000);
        read_elem(0, 1'b1);
        exists_query(16'h1234, 16'hffff);
        repeat (4) exists_query(random_data(), random_data());
        drain_all();
    endtask

    initial begin
        seed = 32'h63be_c6f6;
        for (int i = 0; i < id_queue_pkg::NUM_IDS; i++) begin
            model_count[i] = 0;
        end
        rst_ni = 1'b0;
        drive_idle();
        inp_id_i      = '0;
        inp_data_i    = '0;
        oup_id_i      = '0;
        exists_data_i = '0;
        exists_mask_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        test_empty_state();
        test_fifo_order();
        test_read_vs_pop();
        test_full_refill();
        test_push_priority();
        test_masked_exists();
        // The checker has sampled the last edge by the falling edge after it
        @(negedge clk_i);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: id_queue.f
hdl/id_queue_pkg.sv
hdl/id_queue_lookup.sv
hdl/id_queue_tables.sv
hdl/id_queue_result.sv
hdl/id_queue.sv
dv/id_queue_chk.sv
dv/tb_id_queue.sv

// File: run.sh
#!/bin/sh
# Build and run the ID queue testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_queue -f id_queue.f \
    -o sim_id_queue > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_id_queue > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Simulation FAILED: no pass line"; exit 1; }
echo "Simulation PASSED"
